/* tests/mipsCore_tests.txt */
# P word: program word, address order. T name: a new test begins
# R reg value: expected register write. M wordAddr byteEnable data: expected store
# Checking starts one cycle after reset, so word 0 is a nop
P 00000000
T arith
P 34011234
R 1 00001234
P 3C02ABCD
R 2 ABCD0000
P 00221821
R 3 ABCD1234
P 00222023
R 4 54331234
P 00012900
R 5 00012340
T wordStore
P AC030010
M 04 f ABCD1234
P 8C060010
R 6 ABCD1234
T byteHalf
P A0030020
M 08 1 00000034
P A0030021
M 08 2 00003400
P A0030022
M 08 4 00340000
P A0030023
M 08 8 34000000
P 8C070020
R 7 34343434
P A4030024
M 09 3 00001234
P A4030026
M 09 c 12340000
P 8C080024
R 8 12341234
T leftRight
P A8030033
M 0c f ABCD1234
P A8030032
M 0c 7 00ABCD12
P A8030031
M 0c 3 0000ABCD
P A8030030
M 0c 1 000000AB
P 8C090030
R 9 ABABABAB
P B8030034
M 0d f ABCD1234
P B8030035
M 0d e CD123400
P B8030036
M 0d c 12340000
P B8030037
M 0d 8 34000000
P 8C0A0034
R 10 34343434
T branch
P 10210001
P 340B0BAD
P 10220001
P 340C0C0C
R 12 00000C0C
T jumps
P 0C000021
R 31 0000007C
P 340E000E
P 08000022
# JALR at word 33 returns to word 31, so r15 is written before r14
P 03E07809
R 15 00000088
R 14 0000000E
P 34110094
R 17 00000094
P 02200008
P 34120BAD
T noWrite
P FC000000
P 00220021
P 34131313
R 19 00001313
P 08000028

/* compile.f */
+incdir+source
source/mipsPkg.sv
source/controller.sv
source/alu.sv
source/regFile.sv
source/dataMemory.sv
source/fetchUnit.sv
source/mipsCore.sv
tests/mipsCore_properties.sv
tests/mipsCoreTb.sv

/* run.sh */
#!/bin/sh
# Build and run the mipsCore testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps --top-module mipsCoreTb \
	-f compile.f -Mdir build -o mipsCoreSim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./build/mipsCoreSim > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
	echo "Simulation exited with status $simStatus"
	exit 1
fi

if grep -q "^TEST PASS$" sim.log; then
	exit 0
fi
echo "Pass message not found in sim.log"
exit 1

/* tests/mipsCoreTb.sv */
module mipsCoreTb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int timeoutCycles = 200;
	localparam int tailCycles = 8;

	logic        clk;
	logic        reset;
	logic        loadStrobe;
	logic [7:0]  loadAddress;
	logic [31:0] loadWord;
	logic [31:0] pc;
	logic        regWriteStrobe;
	logic [4:0]  regWriteNumber;
	logic [31:0] regWriteValue;
	logic        memWriteStrobe;
	logic [7:0]  memWriteAddress;
	logic [3:0]  memByteEnable;
	logic [31:0] memWriteData;

	// Program image and expected writes, in execution order
	logic [31:0]     programWords[$];
	logic [4:0]      expRegNumber[$];
	logic [31:0]     expRegValue[$];
	int              expRegTest[$];
	logic [7:0]      expMemAddress[$];
	logic [3:0]      expMemEnable[$];
	logic [31:0]     expMemData[$];
	int              expMemTest[$];
	logic [8*24-1:0] testNames[$];
	int              pending[$];
	int              testErrors[$];

	int errorCount;
	int passCount;
	int idleCycles;
	bit fileOk;
	bit timedOut;

	mipsCore UUT
	(
		.clk, .reset, .loadStrobe, .loadAddress, .loadWord, .pc,
		.regWriteStrobe, .regWriteNumber, .regWriteValue,
		.memWriteStrobe, .memWriteAddress, .memByteEnable, .memWriteData
	);

	initial
	begin
		clk = 1'b0;
		forever
			#4 clk = ~clk;
	end

	////////////////////////////////////////////////////////////////////////////
	// Data file
	////////////////////////////////////////////////////////////////////////////
	task automatic readTests();
		int fd;
		int got;
		int number;
		int c;
		logic [7:0]      kind;
		logic [31:0]     word;
		logic [31:0]     value;
		logic [7:0]      address;
		logic [3:0]      enable;
		logic [8*24-1:0] name;
		fd = $fopen("tests/mipsCore_tests.txt", "r");
		fileOk = (fd != 0);
		if (fileOk)
		begin
			while ($fscanf(fd, " %c", kind) == 1)
			begin
				case (kind)
					"#":
					begin
						c = $fgetc(fd);
						while (c != 10 && c != -1)
							c = $fgetc(fd);
					end
					"P":
					begin
						got = $fscanf(fd, "%h", word);
						fileOk = fileOk && (got == 1);
						programWords.push_back(word);
					end
					"T":
					begin
						got = $fscanf(fd, "%s", name);
						fileOk = fileOk && (got == 1);
						testNames.push_back(name);
						pending.push_back(0);
						testErrors.push_back(0);
					end
					"R":
					begin
						got = $fscanf(fd, "%d %h", number, value);
						fileOk = fileOk && (got == 2) && (testNames.size() > 0);
						expRegNumber.push_back(number[4:0]);
						expRegValue.push_back(value);
						expRegTest.push_back(testNames.size() - 1);
						pending[testNames.size() - 1]++;
					end
					"M":
					begin
						got = $fscanf(fd, "%h %h %h", address, enable, value);
						fileOk = fileOk && (got == 3) && (testNames.size() > 0);
						expMemAddress.push_back(address);
						expMemEnable.push_back(enable);
						expMemData.push_back(value);
						expMemTest.push_back(testNames.size() - 1);
						pending[testNames.size() - 1]++;
					end
					default:
						fileOk = 1'b0;
				endcase
			end
			$fclose(fd);
		end
		fileOk = fileOk && (programWords.size() > 0);
	endtask

	// Reset spans the program load and five more cycles
	task automatic loadProgram();
		for (int i = 0; i < programWords.size(); i++)
		begin
			@(negedge clk);
			loadStrobe = 1'b1;
			loadAddress = i[7:0];
			loadWord = programWords[i];
		end
		@(negedge clk);
		loadStrobe = 1'b0;
		repeat (4)
			@(negedge clk);
		reset = 1'b0;
	endtask

	// Called when an expected write of test t has been seen
	task automatic closeEvent(input int t);
		idleCycles = 0;
		pending[t]--;
		if (pending[t] == 0)
		begin
			if (testErrors[t] == 0)
			begin
				passCount++;
				$display("Test %0s passed", testNames[t]);
			end
			else
				$display("Test %0s failed with %0d errors", testNames[t], testErrors[t]);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Trace checks, sampled on the falling edge
	////////////////////////////////////////////////////////////////////////////
	task automatic checkRegWrite();
		int t;
		if (regWriteStrobe)
		begin
			if (expRegNumber.size() == 0)
			begin
				$display("Unexpected register write to r%0d at %0d ns", regWriteNumber, $time);
				errorCount++;
			end
			else
			begin
				t = expRegTest[0];
				if (regWriteNumber !== expRegNumber[0])
				begin
					$display("Mismatch at %0d ns: regWriteNumber expected %0d, got %0d",
						$time, expRegNumber[0], regWriteNumber);
					errorCount++;
					testErrors[t]++;
				end
				if (regWriteValue !== expRegValue[0])
				begin
					$display("Mismatch at %0d ns: regWriteValue expected %h, got %h",
						$time, expRegValue[0], regWriteValue);
					errorCount++;
					testErrors[t]++;
				end
				void'(expRegNumber.pop_front());
				void'(expRegValue.pop_front());
				void'(expRegTest.pop_front());
				closeEvent(t);
			end
		end
	endtask

	task automatic checkMemWrite();
		int t;
		if (memWriteStrobe)
		begin
			if (expMemAddress.size() == 0)
			begin
				$display("Unexpected memory write to word %h at %0d ns", memWriteAddress, $time);
				errorCount++;
			end
			else
			begin
				t = expMemTest[0];
				if (memWriteAddress !== expMemAddress[0])
				begin
					$display("Mismatch at %0d ns: memWriteAddress expected %h, got %h",
						$time, expMemAddress[0], memWriteAddress);
					errorCount++;
					testErrors[t]++;
				end
				if (memByteEnable !== expMemEnable[0])
				begin
					$display("Mismatch at %0d ns: memByteEnable expected %b, got %b",
						$time, expMemEnable[0], memByteEnable);
					errorCount++;
					testErrors[t]++;
				end
				if (memWriteData !== expMemData[0])
				begin
					$display("Mismatch at %0d ns: memWriteData expected %h, got %h",
						$time, expMemData[0], memWriteData);
					errorCount++;
					testErrors[t]++;
				end
				void'(expMemAddress.pop_front());
				void'(expMemEnable.pop_front());
				void'(expMemData.pop_front());
				void'(expMemTest.pop_front());
				closeEvent(t);
			end
		end
	endtask

	// Last program word is a jump to itself
	task automatic checkHaltPc();
		logic [31:0] haltPc;
		haltPc = 4 * (programWords.size() - 1);
		if (pc !== haltPc)
		begin
			$display("Mismatch at %0d ns: pc expected %h, got %h", $time, haltPc, pc);
			errorCount++;
		end
	endtask

	task automatic runChecks();
		idleCycles = 0;
		while ((expRegNumber.size() > 0 || expMemAddress.size() > 0) && !timedOut)
		begin
			@(negedge clk);
			idleCycles++;
			checkRegWrite();
			checkMemWrite();
			if (idleCycles > timeoutCycles)
			begin
				$display("Timeout at %0d ns: no expected write seen for %0d cycles",
					$time, timeoutCycles);
				timedOut = 1'b1;
			end
		end
		// Program should now sit in its final loop without writing
		if (!timedOut)
		begin
			repeat (tailCycles)
			begin
				@(negedge clk);
				checkRegWrite();
				checkMemWrite();
				checkHaltPc();
			end
		end
	endtask

	initial
	begin
		reset = 1'b1;
		loadStrobe = 1'b0;
		loadAddress = 8'd0;
		loadWord = 32'd0;
		errorCount = 0;
		passCount = 0;
		timedOut = 1'b0;
		readTests();
		if (!fileOk)
			$display("Could not read the test file tests/mipsCore_tests.txt");
		else
		begin
			loadProgram();
			runChecks();
		end
		for (int t = 0; t < testNames.size(); t++)
			if (pending[t] != 0)
				$display("Test %0s did not finish, %0d writes never seen", testNames[t], pending[t]);
		$display("Tests %0d, passed %0d, failed %0d, errors %0d", testNames.size(), passCount,
			testNames.size() - passCount, errorCount);
		if (fileOk && !timedOut && errorCount == 0 && passCount == testNames.size())
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

/* tests/mipsCore_properties.sv */
module mipsCore_properties
(
	input logic        clk,
	input logic        reset,
	input logic [31:0] pc,
	input logic        regWriteStrobe,
	input logic [4:0]  regWriteNumber,
	input logic        memWriteStrobe,
	input logic [3:0]  memByteEnable
);
	timeunit 1ns;
	timeprecision 1ps;

	strobesLowInReset: assert property (@(posedge clk)
		reset |-> !regWriteStrobe && !memWriteStrobe)
		else $error("Write strobe high while reset is asserted");

	// Every store kind enables at least one lane
	storeHasEnables: assert property (@(posedge clk) disable iff (reset)
		memWriteStrobe |-> memByteEnable != 4'b0000)
		else $error("Memory write with no byte enabled");

	pcWordAligned: assert property (@(posedge clk) disable iff (reset)
		pc[1:0] == 2'b00)
		else $error("PC is not word aligned");

	noWriteToZero: assert property (@(posedge clk) disable iff (reset)
		regWriteStrobe |-> regWriteNumber != 5'd0)
		else $error("Register write strobe for r0");

endmodule

bind mipsCore mipsCore_properties checks
(
	.clk, .reset, .pc, .regWriteStrobe, .regWriteNumber, .memWriteStrobe, .memByteEnable
);

/* source/mipsCore.sv */
module mipsCore import mipsPkg::*;
(
	input  logic        clk,
	input  logic        reset,
	input  logic        loadStrobe,
	input  logic [7:0]  loadAddress,
	input  logic [31:0] loadWord,
	output logic [31:0] pc,
	output logic        regWriteStrobe,
	output logic [4:0]  regWriteNumber,
	output logic [31:0] regWriteValue,
	output logic        memWriteStrobe,
	output logic [7:0]  memWriteAddress,
	output logic [3:0]  memByteEnable,
	output logic [31:0] memWriteData
);

	logic [31:0] instruction, linkAddress, rsValue, rtValue;
	logic [31:0] immediate, operandB, aluResult, loadValue;
	logic        isBr, jump, jType, regA3Sel, saveRA, regWE, aluBSel, dmWE, equal;
	regSource    datatoReg;
	extendMode   extCtrl;
	aluCode      aluCtrl;
	storeMode    slCtrl;

	controller decoder (.Opcode(instruction[31:26]), .Funct(instruction[5:0]),
		.IsBr(isBr), .Jump(jump), .JType(jType), .RegA3Sel(regA3Sel), .SaveRA(saveRA),
		.RegWE(regWE), .ALUBSel(aluBSel), .DMWE(dmWE), .DatatoReg(datatoReg),
		.EXTCtrl(extCtrl), .ALUCtrl(aluCtrl), .SLCtrl(slCtrl));

	fetchUnit fetch (.clk, .reset, .loadStrobe, .loadAddress, .loadWord,
		.branchTaken(isBr && equal), .jump, .jumpType(jType), .registerTarget(rsValue),
		.pc, .instruction, .linkAddress);

	regFile registers (.clk, .reset, .readNumberA(instruction[25:21]),
		.readNumberB(instruction[20:16]), .writeNumber(regWriteNumber),
		.writeEnable(regWE), .writeValue(regWriteValue),
		.readValueA(rsValue), .readValueB(rtValue));

	alu arithmetic (.operandA(rsValue), .operandB, .shiftAmount(instruction[10:6]),
		.operation(aluCtrl), .result(aluResult), .equal);

	dataMemory memory (.clk, .reset, .writeEnable(dmWE), .mode(slCtrl),
		.address(aluResult), .storeValue(rtValue), .loadValue,
		.byteEnable(memByteEnable), .laneData(memWriteData));

	// Immediate extension
	always_comb
	begin
		case (extCtrl)
			signExtend:  immediate = {{16{instruction[15]}}, instruction[15:0]};
			upperExtend: immediate = {instruction[15:0], 16'd0};
			default:     immediate = {16'd0, instruction[15:0]};
		endcase
	end

	assign operandB = aluBSel ? immediate : rtValue;

	// Destination: rt for I-type, $ra for JAL, rd otherwise
	assign regWriteNumber = regA3Sel ? instruction[20:16] :
		saveRA ? 5'd31 : instruction[15:11];

	always_comb
	begin
		case (datatoReg)
			fromMemory: regWriteValue = loadValue;
			fromLink:   regWriteValue = linkAddress;
			default:    regWriteValue = aluResult;
		endcase
	end

	assign regWriteStrobe = regWE && (regWriteNumber != 5'd0) && !reset;
	assign memWriteStrobe = dmWE && !reset;
	assign memWriteAddress = aluResult[9:2];

endmodule

/* source/fetchUnit.sv */
`include "mips_consts.svh"

module fetchUnit
(
	input  logic        clk,
	input  logic        reset,
	input  logic        loadStrobe,
	input  logic [7:0]  loadAddress,
	input  logic [31:0] loadWord,
	input  logic        branchTaken,
	input  logic        jump,
	input  logic        jumpType,
	input  logic [31:0] registerTarget,
	output logic [31:0] pc,
	output logic [31:0] instruction,
	output logic [31:0] linkAddress
);

	logic [31:0] instrMemory [`instrDepth];
	logic [31:0] pcPlus4;
	logic [31:0] branchTarget;
	logic [31:0] jumpTarget;
	logic [31:0] nextPc;

	// Program image only accepted while the core is held in reset
	always_ff @(posedge clk)
	begin
		if (reset && loadStrobe)
			instrMemory[loadAddress] <= loadWord;
	end

	assign instruction = instrMemory[pc[9:2]];
	assign pcPlus4 = pc + 32'd4;
	assign linkAddress = pcPlus4;

	////////////////////////////////////////////////////////////////////////////
	// Next PC, no delay slot
	////////////////////////////////////////////////////////////////////////////
	assign branchTarget = pcPlus4 + {{14{instruction[15]}}, instruction[15:0], 2'b00};
	assign jumpTarget = {pcPlus4[31:28], instruction[25:0], 2'b00};

	always_comb
	begin
		if (jump && jumpType)
			nextPc = jumpTarget;
		else if (jump)
			nextPc = registerTarget;
		else if (branchTaken)
			nextPc = branchTarget;
		else
			nextPc = pcPlus4;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			pc <= 32'd0;
		else
			pc <= nextPc;
	end

endmodule

/* source/dataMemory.sv */
`include "mips_consts.svh"

module dataMemory import mipsPkg::*;
(
	input  logic        clk,
	input  logic        reset,
	input  logic        writeEnable,
	input  storeMode    mode,
	input  logic [31:0] address,
	input  logic [31:0] storeValue,
	output logic [31:0] loadValue,
	output logic [3:0]  byteEnable,
	output logic [31:0] laneData
);

	localparam int indexBits = $clog2(`dataDepth);

	logic [31:0] memory [`dataDepth];
	logic [indexBits-1:0] wordIndex;
	logic [1:0] b;

	assign wordIndex = address[indexBits+1:2];
	assign b = address[1:0];

	////////////////////////////////////////////////////////////////////////////
	// Store lanes
	////////////////////////////////////////////////////////////////////////////
	// Bytes are little-endian, unwritten lanes stay zero
	always_comb
	begin
		byteEnable = 4'b0000;
		laneData = 32'd0;
		if (writeEnable)
		begin
			case (mode)
				storeWord:  begin byteEnable = 4'b1111; laneData = storeValue; end
				storeHalf:
				begin
					byteEnable = 4'b0011 << b;
					laneData = {16'd0, storeValue[15:0]} << {b, 3'b000};
				end
				storeByte:
				begin
					byteEnable = 4'b0001 << b;
					laneData = {24'd0, storeValue[7:0]} << {b, 3'b000};
				end
				// Top b+1 bytes land in bytes b..0, 3-b is just ~b
				storeLeft:
				begin
					byteEnable = 4'b1111 >> ~b;
					laneData = storeValue >> {~b, 3'b000};
				end
				storeRight:
				begin
					byteEnable = 4'b1111 << b;
					laneData = storeValue << {b, 3'b000};
				end
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < `dataDepth; i++)
				memory[i] <= 32'd0;
		end
		else
		begin
			for (int i = 0; i < 4; i++)
				if (byteEnable[i])
					memory[wordIndex][8*i +: 8] <= laneData[8*i +: 8];
		end
	end

	assign loadValue = memory[wordIndex];

endmodule

/* source/regFile.sv */
module regFile
(
	input  logic        clk,
	input  logic        reset,
	input  logic [4:0]  readNumberA,
	input  logic [4:0]  readNumberB,
	input  logic [4:0]  writeNumber,
	input  logic        writeEnable,
	input  logic [31:0] writeValue,
	output logic [31:0] readValueA,
	output logic [31:0] readValueB
);

	logic [31:0] registers [32];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < 32; i++)
				registers[i] <= 32'd0;
		end
		// Writes to $zero are dropped
		else if (writeEnable && writeNumber != 5'd0)
			registers[writeNumber] <= writeValue;
	end

	assign readValueA = (readNumberA == 5'd0) ? 32'd0 : registers[readNumberA];
	assign readValueB = (readNumberB == 5'd0) ? 32'd0 : registers[readNumberB];

endmodule

/* source/alu.sv */
`include "mips_consts.svh"

module alu import mipsPkg::*;
(
	input  logic [31:0] operandA,
	input  logic [31:0] operandB,
	input  logic [4:0]  shiftAmount,
	input  aluCode      operation,
	output logic [31:0] result,
	output logic        equal
);

	// BEQ reads this directly, whatever the operation
	assign equal = (operandA == operandB);

	always_comb
	begin
		case (operation)
			`aluAdd:
				result = operandA + operandB;
			`aluSub:
				result = operandA - operandB;
			// Shift source is rt on the B side
			`aluSll:
				result = operandB << shiftAmount;
			`aluOr:
				result = operandA | operandB;
			`aluEq:
				result = {31'd0, equal};
			default:
				result = 32'd0;
		endcase
	end

endmodule

/* source/controller.sv */
`include "mips_consts.svh"

module controller import mipsPkg::*;
(
	input  logic [5:0] Opcode,
	input  logic [5:0] Funct,
	output logic       IsBr,
	output logic       Jump,
	output logic       JType,
	output logic       RegA3Sel,
	output logic       SaveRA,
	output logic       RegWE,
	output logic       ALUBSel,
	output logic       DMWE,
	output regSource   DatatoReg,
	output extendMode  EXTCtrl,
	output aluCode     ALUCtrl,
	output storeMode   SLCtrl
);

	always_comb
	begin
		// Anything not listed below is a no-op
		IsBr      = 1'b0;
		Jump      = 1'b0;
		JType     = 1'b0;
		RegA3Sel  = 1'b0;
		SaveRA    = 1'b0;
		RegWE     = 1'b0;
		ALUBSel   = 1'b0;
		DMWE      = 1'b0;
		DatatoReg = fromAlu;
		EXTCtrl   = zeroExtend;
		ALUCtrl   = '0;
		SLCtrl    = noStore;

		case (Opcode)
			`opcodeR:
			begin
				case (Funct)
					`functADDU: begin RegWE = 1'b1; ALUCtrl = `aluAdd; end
					`functSUBU: begin RegWE = 1'b1; ALUCtrl = `aluSub; end
					`functSLL:  begin RegWE = 1'b1; ALUCtrl = `aluSll; end
					`functJR:   Jump = 1'b1;
					// Link goes to rd
					`functJALR: begin Jump = 1'b1; RegWE = 1'b1; DatatoReg = fromLink; end
					default:    ;
				endcase
			end
			`opcodeORI:
			begin
				RegA3Sel = 1'b1; RegWE = 1'b1; ALUBSel = 1'b1; ALUCtrl = `aluOr;
			end
			`opcodeLUI:
			begin
				RegA3Sel = 1'b1; RegWE = 1'b1; ALUBSel = 1'b1; ALUCtrl = `aluOr;
				EXTCtrl = upperExtend;
			end
			`opcodeLW:
			begin
				RegA3Sel = 1'b1; RegWE = 1'b1; ALUBSel = 1'b1; ALUCtrl = `aluAdd;
				DatatoReg = fromMemory; EXTCtrl = signExtend; SLCtrl = storeWord;
			end
			`opcodeSW, `opcodeSH, `opcodeSB, `opcodeSWL, `opcodeSWR:
			begin
				ALUBSel = 1'b1; DMWE = 1'b1; ALUCtrl = `aluAdd; EXTCtrl = signExtend;
				case (Opcode)
					`opcodeSH:  SLCtrl = storeHalf;
					`opcodeSB:  SLCtrl = storeByte;
					`opcodeSWL: SLCtrl = storeLeft;
					`opcodeSWR: SLCtrl = storeRight;
					default:    SLCtrl = storeWord;
				endcase
			end
			`opcodeBEQ: begin IsBr = 1'b1; EXTCtrl = signExtend; ALUCtrl = `aluEq; end
			`opcodeJ:   begin Jump = 1'b1; JType = 1'b1; end
			`opcodeJAL:
			begin
				Jump = 1'b1; JType = 1'b1; SaveRA = 1'b1; RegWE = 1'b1; DatatoReg = fromLink;
			end
			default: ;
		endcase
	end

endmodule

/* source/mipsPkg.sv */
package mipsPkg;

	// Write-back source for the register file
	typedef enum logic [1:0]
	{
		fromAlu    = 2'b00,
		fromMemory = 2'b01,
		fromLink   = 2'b10
	} regSource;

	// Immediate extension, upper puts imm in bits 31..16
	typedef enum logic [1:0]
	{
		zeroExtend  = 2'b00,
		signExtend  = 2'b01,
		upperExtend = 2'b10
	} extendMode;

	// Store width and alignment
	typedef enum logic [2:0]
	{
		noStore, storeWord, storeHalf, storeByte, storeLeft, storeRight
	} storeMode;

	// One-hot ALU operation
	typedef logic [7:0] aluCode;

endpackage

/* source/mips_consts.svh */
`ifndef MIPS_CONSTS_SVH
`define MIPS_CONSTS_SVH

////////////////////////////////////////////////////////////////////////////
// Primary opcodes, instruction bits 31..26
////////////////////////////////////////////////////////////////////////////
`define opcodeR    6'b000000
`define opcodeJ    6'b000010
`define opcodeJAL  6'b000011
`define opcodeBEQ  6'b000100
`define opcodeORI  6'b001101
`define opcodeLUI  6'b001111
`define opcodeLW   6'b100011
`define opcodeSB   6'b101000
`define opcodeSH   6'b101001
`define opcodeSWL  6'b101010
`define opcodeSW   6'b101011
`define opcodeSWR  6'b101110

// R-type funct field, bits 5..0
`define functSLL   6'b000000
`define functJR    6'b001000
`define functJALR  6'b001001
`define functADDU  6'b100001
`define functSUBU  6'b100011

////////////////////////////////////////////////////////////////////////////
// ALU operations, one hot
////////////////////////////////////////////////////////////////////////////
`define aluAdd     8'b0000_0001
`define aluSub     8'b0000_0010
`define aluSll     8'b0000_0100
`define aluOr      8'b0000_1000
`define aluEq      8'b0001_0000

// Memory sizes in 32-bit words
`define instrDepth 256
`define dataDepth  256

`endif
